// ==== term_pkg.sv ====
package term_pkg;

	// Control bytes
	localparam logic [7:0] CHAR_BS  = 8'h08;
	localparam logic [7:0] CHAR_LF  = 8'h0a;
	localparam logic [7:0] CHAR_VT  = 8'h0b;
	localparam logic [7:0] CHAR_FF  = 8'h0c;
	localparam logic [7:0] CHAR_CR  = 8'h0d;
	localparam logic [7:0] CHAR_ESC = 8'h1b;

	typedef enum logic [4:0] {
		NONE,
		INPUT,    // Printed or control byte
		CUP,      // Cursor position
		CUF,
		CUB,
		CUD,
		CUU,
		VPA,      // Line absolute
		CHA,      // Column absolute
		IND,
		RI,
		NEL,
		DECSTBM,  // Scroll margins
		DECSET,
		DECRST
	} command_t;

	typedef struct packed {
		logic [7:0] x;  // Line
		logic [7:0] y;  // Column
	} cursor_t;

	typedef struct packed {
		logic [7:0] pn1;  // Zero when absent
		logic [7:0] pn2;
		logic [7:0] pchar;
	} param_t;

	typedef struct packed {
		logic origin_mode;
		logic auto_wrap;
		logic cursor_visible;
		logic cursor_blinking;
	} mode_t;

	typedef struct packed {
		logic [7:0] scroll_top;
		logic [7:0] scroll_bottom;
	} attrib_t;

	typedef struct packed {
		mode_t   mode;
		attrib_t attrib;
		cursor_t cursor;
		logic    prev_data;
	} terminal_t;

	typedef struct packed {
		logic       dir;    // 0 up, 1 down
		logic [7:0] step;
		logic [7:0] top;
		logic [7:0] bottom;
		logic       reset;  // CUP below the region, origin mode off
	} scrolling_t;

	function automatic logic is_printable(input logic [7:0] b);
		return (b >= 8'h20) && (b != 8'h7f);
	endfunction

endpackage

// ==== esc_parser.sv ====
`timescale 1ns/100ps

module esc_parser
	import term_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       i_byte_valid,
	input  logic [7:0] i_byte,
	output logic       o_cmd_valid,
	output command_t   o_cmd,
	output param_t     o_param
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ESCAPE,
		ST_CSI,
		ST_PRIVATE
	} state_t;

	state_t     state;
	state_t     state_nxt;
	command_t   cmd_nxt;
	logic [7:0] pn1_q;
	logic [7:0] pn2_q;
	logic       sel_q;     // Collecting second parameter
	logic       is_digit;

	// One more decimal digit, held at 255 on overflow
	function automatic logic [7:0] acc_digit(input logic [7:0] acc, input logic [7:0] ch);
		logic [11:0] sum;
		sum = {4'd0, acc} * 12'd10 + {8'd0, ch[3:0]};
		return (sum > 12'd255) ? 8'hff : sum[7:0];
	endfunction

	function automatic command_t csi_final(input logic [7:0] ch, input logic priv);
		command_t c;
		case (ch)
			"H": c = CUP;
			"C": c = CUF;
			"D": c = CUB;
			"B": c = CUD;
			"A": c = CUU;
			"d": c = VPA;
			"G": c = CHA;
			"r": c = DECSTBM;
			"h": c = DECSET;
			"l": c = DECRST;
			default: c = NONE;
		endcase
		if (priv && (c != DECSET) && (c != DECRST))
			c = NONE;  // '?' only goes with h and l
		return c;
	endfunction

	assign is_digit = (i_byte >= "0") && (i_byte <= "9");

	always_comb
	begin
		state_nxt = state;
		cmd_nxt   = NONE;
		if (i_byte_valid)
		begin
			if (i_byte == CHAR_ESC)
				state_nxt = ST_ESCAPE;  // Restarts any open sequence
			else
			begin
				case (state)
					ST_IDLE:
						cmd_nxt = INPUT;
					ST_ESCAPE:
					begin
						state_nxt = (i_byte == "[") ? ST_CSI : ST_IDLE;
						case (i_byte)
							"D": cmd_nxt = IND;
							"E": cmd_nxt = NEL;
							"M": cmd_nxt = RI;
							default: cmd_nxt = NONE;
						endcase
					end
					default:  // CSI body
					begin
						if ((i_byte == "?") && (state == ST_CSI))
							state_nxt = ST_PRIVATE;
						else if (!is_digit && (i_byte != ";"))
						begin
							state_nxt = ST_IDLE;  // Final byte, known or not
							cmd_nxt   = csi_final(i_byte, state == ST_PRIVATE);
						end
					end
				endcase
			end
		end
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state       <= ST_IDLE;
			o_cmd_valid <= 1'b0;
			o_cmd       <= NONE;
		end
		else
		begin
			state       <= state_nxt;
			o_cmd_valid <= (cmd_nxt != NONE);
			o_cmd       <= cmd_nxt;
		end
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			pn1_q <= 8'd0;
			pn2_q <= 8'd0;
			sel_q <= 1'b0;
		end
		else if (i_byte_valid)
		begin
			if (i_byte == CHAR_ESC)
			begin
				pn1_q <= 8'd0;
				pn2_q <= 8'd0;
				sel_q <= 1'b0;
			end
			else if ((state == ST_CSI) || (state == ST_PRIVATE))
			begin
				if (i_byte == ";")
					sel_q <= 1'b1;  // Further fields fold into pn2
				else if (is_digit && !sel_q)
					pn1_q <= acc_digit(pn1_q, i_byte);
				else if (is_digit)
					pn2_q <= acc_digit(pn2_q, i_byte);
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (i_byte_valid)
			o_param <= '{pn1: pn1_q, pn2: pn2_q, pchar: i_byte};
	end

endmodule

// ==== term_state.sv ====
`timescale 1ns/100ps

module term_state
	import term_pkg::*;
#(
	parameter int LINES = 24
)
(
	input  logic     clk,
	input  logic     rst,
	input  logic     i_cmd_valid,
	input  command_t i_cmd,
	input  param_t   i_param,
	output mode_t    o_mode,
	output attrib_t  o_attrib,
	output logic     o_prev_data
);

	localparam logic [7:0] LAST_LINE = 8'(LINES - 1);

	logic [7:0] new_top;
	logic [7:0] new_bottom;
	logic       margins_ok;
	logic       mode_val;    // 1 for DECSET

	assign new_top    = (i_param.pn1 == 8'd0) ? 8'd0 : i_param.pn1 - 8'd1;
	assign new_bottom = (i_param.pn2 == 8'd0) ? LAST_LINE : i_param.pn2 - 8'd1;
	assign margins_ok = (new_top < new_bottom) && (new_bottom <= LAST_LINE);
	assign mode_val   = (i_cmd == DECSET);

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			o_mode      <= '{origin_mode: 1'b0, auto_wrap: 1'b1,
				cursor_visible: 1'b1, cursor_blinking: 1'b0};
			o_attrib    <= '{scroll_top: 8'd0, scroll_bottom: LAST_LINE};
			o_prev_data <= 1'b0;
		end
		else if (i_cmd_valid)
		begin
			// Only a printed character directly before counts
			o_prev_data <= (i_cmd == INPUT) && is_printable(i_param.pchar);
			case (i_cmd)
				DECSTBM:
				begin
					if (margins_ok)
					begin
						o_attrib.scroll_top    <= new_top;
						o_attrib.scroll_bottom <= new_bottom;
					end
				end
				DECSET, DECRST:
				begin
					case (i_param.pn1)
						8'd6:  o_mode.origin_mode     <= mode_val;
						8'd7:  o_mode.auto_wrap       <= mode_val;
						8'd12: o_mode.cursor_blinking <= mode_val;
						8'd25: o_mode.cursor_visible  <= mode_val;
						default: ;  // Other modes not kept
					endcase
				end
				default: ;
			endcase
		end
	end

endmodule

// ==== cursor_control.sv ====
`timescale 1ns/100ps

module cursor_control
	import term_pkg::*;
#(
	parameter int LINES   = 24,
	parameter int COLUMNS = 80
)
(
	input  logic       clk,
	input  logic       rst,
	input  logic       i_cmd_valid,
	input  command_t   i_cmd,
	input  param_t     i_param,
	input  terminal_t  i_term,
	input  logic       i_blink_phase,
	output cursor_t    o_cursor,
	output logic       o_cursor_visible,
	output scrolling_t o_scroll,
	output logic       o_scroll_valid
);

	localparam logic [7:0] LAST_LINE = 8'(LINES - 1);
	localparam logic [7:0] LAST_COL  = 8'(COLUMNS - 1);

	logic [7:0] top;
	logic [7:0] bottom;
	logic [7:0] origin_x;   // Absolute line of relative line 0
	logic [7:0] x_max;      // Highest relative line for CUP and VPA
	logic [7:0] cx;
	logic [7:0] cy;
	logic [7:0] pl;
	logic [7:0] pc;
	logic [7:0] pn;
	logic [7:0] abs_line;   // CUP and VPA target
	logic [7:0] next_x;
	logic       at_bottom;
	logic [7:0] down_lim;
	logic [7:0] up_lim;
	logic [8:0] right_sum;
	logic [8:0] down_sum;
	logic [8:0] up_floor;
	cursor_t    rel_q;      // Kept relative to the origin line
	cursor_t    nxt;        // Next absolute position
	logic       home;
	logic       scroll_up;
	logic       scroll_down;
	logic       scroll_dir_q;
	logic [7:0] scroll_top_q;
	logic [7:0] scroll_bottom_q;

	assign top      = i_term.attrib.scroll_top;
	assign bottom   = i_term.attrib.scroll_bottom;
	assign origin_x = i_term.mode.origin_mode ? top : 8'd0;
	assign x_max    = i_term.mode.origin_mode ? bottom - top : LAST_LINE;
	assign cx       = i_term.cursor.x;
	assign cy       = i_term.cursor.y;

	assign pl = (i_param.pn1 == 8'd0) ? 8'd0 : i_param.pn1 - 8'd1;  // Line
	assign pc = (i_param.pn2 == 8'd0) ? 8'd0 : i_param.pn2 - 8'd1;  // Column
	assign pn = (i_param.pn1 == 8'd0) ? 8'd1 : i_param.pn1;         // Count

	assign abs_line  = origin_x + ((pl > x_max) ? x_max : pl);
	assign at_bottom = (cx == bottom);
	assign next_x    = (at_bottom || (cx == LAST_LINE)) ? cx : cx + 8'd1;

	// Vertical moves stop at a margin only from inside the region
	assign down_lim  = (cx > bottom) ? LAST_LINE : bottom;
	assign up_lim    = (cx < top) ? 8'd0 : top;
	assign right_sum = {1'b0, cy} + {1'b0, pn};
	assign down_sum  = {1'b0, cx} + {1'b0, pn};
	assign up_floor  = {1'b0, up_lim} + {1'b0, pn};

	always_comb
	begin
		nxt         = i_term.cursor;
		home        = 1'b0;
		scroll_up   = 1'b0;
		scroll_down = 1'b0;
		case (i_cmd)
			CUP:
			begin
				nxt.x = abs_line;
				nxt.y = (pc > LAST_COL) ? LAST_COL : pc;
			end
			VPA: nxt.x = abs_line;
			CHA: nxt.y = (pl > LAST_COL) ? LAST_COL : pl;
			CUF: nxt.y = (right_sum > {1'b0, LAST_COL}) ? LAST_COL : right_sum[7:0];
			CUB: nxt.y = (cy < pn) ? 8'd0 : cy - pn;
			CUD: nxt.x = (down_sum > {1'b0, down_lim}) ? down_lim : down_sum[7:0];
			CUU: nxt.x = ({1'b0, cx} < up_floor) ? up_lim : cx - pn;
			IND, NEL:
			begin
				nxt.x     = next_x;
				scroll_up = at_bottom;
				if (i_cmd == NEL)
					nxt.y = 8'd0;
			end
			RI:
			begin
				if (cx == top)
					scroll_down = 1'b1;  // Line held at the top margin
				else if (cx != 8'd0)
					nxt.x = cx - 8'd1;
			end
			DECSTBM: home = 1'b1;
			DECSET, DECRST: home = (i_param.pn1 == 8'd6);  // Origin switch homes
			INPUT:
			begin
				case (i_param.pchar)
					CHAR_LF, CHAR_VT, CHAR_FF:
					begin
						nxt.x     = next_x;
						scroll_up = at_bottom;
					end
					CHAR_CR: nxt.y = 8'd0;
					CHAR_BS: nxt.y = (cy == 8'd0) ? 8'd0 : cy - 8'd1;
					default:
					begin
						if (is_printable(i_param.pchar))
						begin
							if (cy < LAST_COL)
								nxt.y = cy + 8'd1;
							else if (i_term.mode.auto_wrap)
							begin
								nxt.x     = next_x;
								nxt.y     = 8'd0;
								scroll_up = at_bottom;
							end
						end
					end
				endcase
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			rel_q          <= '0;
			o_scroll_valid <= 1'b0;
		end
		else
		begin
			o_scroll_valid <= i_cmd_valid && (scroll_up || scroll_down);
			if (i_cmd_valid && home)
				rel_q <= '0;  // Lands on the new origin line
			else if (i_cmd_valid)
			begin
				rel_q.x <= nxt.x - origin_x;
				rel_q.y <= nxt.y;
			end
		end
	end

	// Scroll record, margins as they were at the request
	always_ff @(posedge clk)
	begin
		if (i_cmd_valid && (scroll_up || scroll_down))
		begin
			scroll_dir_q    <= scroll_down;
			scroll_top_q    <= top;
			scroll_bottom_q <= bottom;
		end
	end

	assign o_scroll.dir    = scroll_dir_q;
	assign o_scroll.step   = 8'd1;  // Every scroll moves one line
	assign o_scroll.top    = scroll_top_q;
	assign o_scroll.bottom = scroll_bottom_q;
	assign o_scroll.reset  = i_cmd_valid && (i_cmd == CUP) &&
		!i_term.mode.origin_mode && (pl > bottom);

	assign o_cursor.x = origin_x + rel_q.x;
	assign o_cursor.y = rel_q.y;

	assign o_cursor_visible = i_term.mode.cursor_blinking ?
		(i_term.mode.cursor_visible & i_blink_phase) : i_term.mode.cursor_visible;

endmodule

// ==== blink_timer.sv ====
`timescale 1ns/100ps

module blink_timer #(
	parameter int BLINK_CYCLES = 16
)
(
	input  logic clk,
	input  logic rst,
	output logic o_blink_phase
);

	localparam int CW = (BLINK_CYCLES > 1) ? $clog2(BLINK_CYCLES) : 1;

	logic [CW-1:0] count;

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			count         <= '0;
			o_blink_phase <= 1'b0;
		end
		else if (count == CW'(BLINK_CYCLES - 1))
		begin
			count         <= '0;
			o_blink_phase <= ~o_blink_phase;  // Phase lasts BLINK_CYCLES
		end
		else
			count <= count + 1'b1;
	end

endmodule

// ==== term_top.sv ====
`timescale 1ns/100ps

module term_top
	import term_pkg::*;
#(
	parameter int LINES        = 24,
	parameter int COLUMNS      = 80,
	parameter int BLINK_CYCLES = 16
)
(
	input  logic       clk,
	input  logic       rst,
	input  logic       i_byte_valid,
	input  logic [7:0] i_byte,
	output cursor_t    o_cursor,
	output logic       o_cursor_visible,
	output scrolling_t o_scroll,
	output logic       o_scroll_valid
);

	logic      cmd_valid;
	command_t  cmd;
	param_t    param;
	mode_t     mode;
	attrib_t   attrib;
	logic      prev_data;
	logic      blink_phase;
	terminal_t term;

	// Cursor comes back from its own block
	assign term = '{mode: mode, attrib: attrib, cursor: o_cursor, prev_data: prev_data};

	esc_parser u_parser (
		.clk          (clk),
		.rst          (rst),
		.i_byte_valid (i_byte_valid),
		.i_byte       (i_byte),
		.o_cmd_valid  (cmd_valid),
		.o_cmd        (cmd),
		.o_param      (param)
	);

	term_state #(
		.LINES (LINES)
	) u_state (
		.clk         (clk),
		.rst         (rst),
		.i_cmd_valid (cmd_valid),
		.i_cmd       (cmd),
		.i_param     (param),
		.o_mode      (mode),
		.o_attrib    (attrib),
		.o_prev_data (prev_data)
	);

	cursor_control #(
		.LINES   (LINES),
		.COLUMNS (COLUMNS)
	) u_cursor (
		.clk              (clk),
		.rst              (rst),
		.i_cmd_valid      (cmd_valid),
		.i_cmd            (cmd),
		.i_param          (param),
		.i_term           (term),
		.i_blink_phase    (blink_phase),
		.o_cursor         (o_cursor),
		.o_cursor_visible (o_cursor_visible),
		.o_scroll         (o_scroll),
		.o_scroll_valid   (o_scroll_valid)
	);

	blink_timer #(
		.BLINK_CYCLES (BLINK_CYCLES)
	) u_blink (
		.clk           (clk),
		.rst           (rst),
		.o_blink_phase (blink_phase)
	);

endmodule

// ==== term_properties.sv ====
`timescale 1ns/100ps

module term_properties
	import term_pkg::*;
#(
	parameter int LINES   = 24,
	parameter int COLUMNS = 80
)
(
	input logic    clk,
	input logic    rst,
	input logic    i_cmd_valid,
	input logic    i_scroll_valid,
	input cursor_t i_cursor
);

	// Parser emits single-cycle command pulses
	property cmd_single_cycle;
		@(posedge clk) disable iff (rst)
		i_cmd_valid |=> !i_cmd_valid;
	endproperty

	property scroll_after_cmd;
		@(posedge clk) disable iff (rst)
		i_scroll_valid |-> $past(i_cmd_valid);
	endproperty

	property cursor_in_grid;
		@(posedge clk) disable iff (rst)
		(i_cursor.x < LINES) && (i_cursor.y < COLUMNS);
	endproperty

	a_cmd_single: assert property (cmd_single_cycle)
		else $error("cmd_valid stayed high for two cycles");

	a_scroll_after_cmd: assert property (scroll_after_cmd)
		else $error("o_scroll_valid without a command in the cycle before");

	a_cursor_in_grid: assert property (cursor_in_grid)
		else $error("Cursor outside the grid at line %0d column %0d", i_cursor.x, i_cursor.y);

endmodule

// ==== term_tb.sv ====
`timescale 1ns/100ps

module term_tb
	import term_pkg::*;
();

	localparam int LINES          = 24;
	localparam int COLUMNS        = 80;
	localparam int BLINK_CYCLES   = 16;
	localparam int CLK_PERIOD     = 20;
	localparam int BYTE_BUDGET    = 500;  // Upper bound on bytes sent by all tests
	localparam int TIMEOUT_CYCLES = BYTE_BUDGET * 4 + 1000;

	logic       clk;
	logic       rst;
	logic       byte_valid;
	logic [7:0] byte_in;
	cursor_t    cursor;
	logic       cursor_visible;
	scrolling_t scroll;
	logic       scroll_valid;

	logic        last_scroll_valid;  // Sampled after each byte
	scrolling_t  last_scroll;
	logic        last_scroll_reset;  // Sampled in the command cycle

	term_top dut0 (
		.clk              (clk),
		.rst              (rst),
		.i_byte_valid     (byte_valid),
		.i_byte           (byte_in),
		.o_cursor         (cursor),
		.o_cursor_visible (cursor_visible),
		.o_scroll         (scroll),
		.o_scroll_valid   (scroll_valid)
	);

	bind term_top term_properties #(
		.LINES   (LINES),
		.COLUMNS (COLUMNS)
	) props0 (
		.clk            (clk),
		.rst            (rst),
		.i_cmd_valid    (cmd_valid),
		.i_scroll_valid (o_scroll_valid),
		.i_cursor       (o_cursor)
	);

	initial
		clk = 1'b0;

	always #(CLK_PERIOD / 2) clk = ~clk;

	// Watchdog
	initial
	begin
		#(TIMEOUT_CYCLES * CLK_PERIOD);
		$display("Run timed out after %0d cycles", TIMEOUT_CYCLES);
		$display("TEST FAIL");
		$fatal(1, "Watchdog expired");
	end

	task automatic check(input string name, input int expected, input int actual);
		if (expected != actual)
		begin
			$display("Fail %s: expected %0d, actual %0d", name, expected, actual);
			$display("TEST FAIL");
			$fatal(1, "Mismatch in %s", name);
		end
	endtask

	// Numeric parameter to index, absent or 0 gives 0
	function automatic int to_index(input int p);
		return (p == 0) ? 0 : p - 1;
	endfunction

	function automatic int limit(input int v, input int hi);
		return (v > hi) ? hi : v;
	endfunction

	// Starts and ends on a falling edge, two cycles per byte
	task automatic send_byte(input logic [7:0] b);
		byte_valid = 1'b1;
		byte_in    = b;
		@(negedge clk);
		byte_valid        = 1'b0;
		last_scroll_reset = scroll.reset;
		@(negedge clk);
		last_scroll_valid = scroll_valid;
		last_scroll       = scroll;
	endtask

	task automatic send_string(input string s);
		for (int i = 0; i < s.len(); i++)
			send_byte(s[i]);
	endtask

	task automatic send_csi(input string body);
		send_byte(CHAR_ESC);
		send_byte("[");
		send_string(body);
	endtask

	task automatic send_esc(input logic [7:0] final_byte);
		send_byte(CHAR_ESC);
		send_byte(final_byte);
	endtask

	task automatic check_cursor(input string name, input int x, input int y);
		check({name, " line"}, x, cursor.x);
		check({name, " column"}, y, cursor.y);
	endtask

	task automatic check_scroll(input string name, input int dir, input int top,
		input int bottom);
		check({name, " scroll valid"}, 1, last_scroll_valid);
		check({name, " scroll dir"}, dir, last_scroll.dir);
		check({name, " scroll step"}, 1, last_scroll.step);
		check({name, " scroll top"}, top, last_scroll.top);
		check({name, " scroll bottom"}, bottom, last_scroll.bottom);
	endtask

	task automatic absolute_positioning();
		int l;
		int c;
		int ex;
		int ey;
		for (int i = 0; i < 10; i++)
		begin
			l = (i == 0) ? 0 : (i == 1) ? 99 : $urandom_range(0, 40);
			c = (i == 0) ? 0 : (i == 1) ? 200 : $urandom_range(0, 100);
			ex = limit(to_index(l), LINES - 1);
			ey = limit(to_index(c), COLUMNS - 1);
			send_csi($sformatf("%0d;%0dH", l, c));
			check_cursor($sformatf("CUP %0d;%0d", l, c), ex, ey);
		end
		for (int i = 0; i < 4; i++)
		begin
			l = $urandom_range(0, 40);
			ex = limit(to_index(l), LINES - 1);
			send_csi($sformatf("%0dd", l));
			check($sformatf("VPA %0d", l), ex, cursor.x);
			check($sformatf("VPA %0d column", l), ey, cursor.y);  // Column kept
			c = $urandom_range(0, 100);
			ey = limit(to_index(c), COLUMNS - 1);
			send_csi($sformatf("%0dG", c));
			check_cursor($sformatf("CHA %0d", c), ex, ey);
		end
	endtask

	task automatic relative_moves();
		send_csi("10;40H");
		check_cursor("CUP 10;40", 9, 39);
		send_csi("C");
		check_cursor("CUF default", 9, 40);
		send_csi("5C");
		check_cursor("CUF 5", 9, 45);
		send_csi("200C");
		check_cursor("CUF past edge", 9, COLUMNS - 1);
		send_csi("D");
		check_cursor("CUB default", 9, COLUMNS - 2);
		send_csi("100D");
		check_cursor("CUB past edge", 9, 0);
		send_csi("B");
		check_cursor("CUD default", 10, 0);
		send_csi("50B");
		check_cursor("CUD past bottom", LINES - 1, 0);
		send_csi("A");
		check_cursor("CUU default", LINES - 2, 0);
		send_csi("99A");
		check_cursor("CUU past top", 0, 0);
		send_csi("3;10H");
		send_byte(CHAR_BS);
		check_cursor("BS", 2, 8);
		send_byte(CHAR_CR);
		check_cursor("CR", 2, 0);
		send_byte(CHAR_BS);
		check_cursor("BS at column 0", 2, 0);
	endtask

	task automatic printing_wrap();
		send_csi("1;1H");
		send_string("hi");
		check_cursor("print two", 0, 2);
		send_csi("1;79H");
		send_byte("A");
		check_cursor("print to last column", 0, COLUMNS - 1);
		send_byte("B");
		check_cursor("auto wrap", 1, 0);
		send_csi("?7l");
		send_csi("2;79H");
		send_string("xyz");
		check_cursor("no wrap", 1, COLUMNS - 1);
		send_csi("?7h");
	endtask

	task automatic margin_scrolling();
		send_csi("5;10r");
		check_cursor("DECSTBM home", 0, 0);
		send_csi("10;1H");
		check_cursor("CUP bottom margin", 9, 0);
		check("CUP no scroll", 0, last_scroll_valid);
		send_esc("D");
		check_cursor("IND bottom", 9, 0);
		check_scroll("IND bottom", 0, 4, 9);
		send_byte(CHAR_LF);
		check_cursor("LF bottom", 9, 0);
		check_scroll("LF bottom", 0, 4, 9);
		send_csi("10;80H");
		send_byte("Z");
		check_cursor("wrap bottom", 9, 0);
		check_scroll("wrap bottom", 0, 4, 9);
		send_csi("6;1H");
		send_csi("20B");
		check_cursor("CUD to margin", 9, 0);
		send_csi("9A");
		check_cursor("CUU to margin", 4, 0);
		send_esc("M");
		check_cursor("RI top", 4, 0);
		check_scroll("RI top", 1, 4, 9);
	endtask

	task automatic origin_translation();
		send_csi("?6h");
		check_cursor("origin on home", 4, 0);
		send_csi("1;1H");
		check_cursor("origin CUP 1;1", 4, 0);
		send_csi("3;5H");
		check_cursor("origin CUP 3;5", 6, 4);
		send_csi("20;1H");
		check_cursor("origin CUP past region", 9, 0);
		check("origin CUP reset", 0, last_scroll_reset);
		send_csi("?6l");
		check_cursor("origin off home", 0, 0);
		send_csi("5;1H");
		check("CUP inside reset", 0, last_scroll_reset);
		send_csi("15;1H");
		check_cursor("CUP below region", 14, 0);
		check("CUP below region reset", 1, last_scroll_reset);
		send_csi("r");
		check_cursor("default margins home", 0, 0);
		send_csi("30B");
		check_cursor("full screen CUD", LINES - 1, 0);
	endtask

	task automatic visibility_blink();
		logic prev;
		logic level;
		int   waited;
		send_csi("?25l");
		check("hidden cursor", 0, cursor_visible);
		send_csi("?25h");
		check("shown cursor", 1, cursor_visible);
		send_csi("?12h");
		// Find a phase edge, then each phase must last BLINK_CYCLES cycles
		prev   = cursor_visible;
		waited = 0;
		while ((cursor_visible == prev) && (waited < 2 * BLINK_CYCLES))
		begin
			@(negedge clk);
			waited++;
		end
		check("blink toggles", 1, cursor_visible != prev);
		for (int p = 0; p < 2; p++)
		begin
			level = cursor_visible;
			for (int i = 0; i < BLINK_CYCLES; i++)
			begin
				check($sformatf("blink phase %0d cycle %0d", p, i), level, cursor_visible);
				@(negedge clk);
			end
			check($sformatf("blink phase %0d end", p), !level, cursor_visible);
		end
		send_csi("?12l");
		check("blink off", 1, cursor_visible);
	endtask

	initial
	begin
		rst        = 1'b1;
		byte_valid = 1'b0;
		byte_in    = 8'd0;
		void'($urandom(32'h1776));
		repeat (4) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		check_cursor("after reset", 0, 0);
		check("visible after reset", 1, cursor_visible);
		absolute_positioning();
		relative_moves();
		printing_wrap();
		margin_scrolling();
		origin_translation();
		visibility_blink();
		$display("TEST PASS");
		$finish;
	end

endmodule

// ==== vlog.f ====
term_pkg.sv
esc_parser.sv
term_state.sv
cursor_control.sv
blink_timer.sv
term_top.sv
term_properties.sv
term_tb.sv
